// File: locator_top.f
logic/locator_pkg.sv
logic/calc_rsin.sv
logic/polar_to_cartesian.sv
logic/nearest_target_tracker.sv
logic/fix_smoother.sv
logic/locator_top.sv
sim/locator_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the locator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   --top-module locator_tb \
   -f locator_top.f \
   --Mdir obj_dir -o locator_sim

out="$(./obj_dir/locator_sim)"
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
   exit 0
else
   exit 1
fi

// File: sim/locator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module locator_tb import locator_pkg::*;;

   logic    clk = 1'b0;
   logic    arst_n;
   logic    sample_valid;
   sample_t sample;
   logic    fix_valid;
   fix_t    fix;
   logic    smooth_valid;
   point_t  smooth_pos;

   int      seed = 25304;
   int      cycle = 0;   // rising edges since start
   int      errors = 0;
   int      checks = 0;
   int      tests = 0;
   int      test_err0;    // error count when the running test began
   int      test_chk0;
   string   test_name;

   logic [3:0] theta_codes [6];
   logic [7:0] sweep_r [6]; // one range per bearing for the next sweep

   // reference model state
   fix_t   best;
   logic   ref_primed;
   point_t ref_smooth;

   // expected pulses and the cycle each one is due in
   fix_t   fix_exp_q [$];
   int     fix_cyc_q [$];
   point_t pt_exp_q [$];
   int     pt_cyc_q [$];

   locator_top dut0 (
      .clk          (clk),
      .arst_n       (arst_n),
      .sample_valid (sample_valid),
      .sample       (sample),
      .fix_valid    (fix_valid),
      .fix          (fix),
      .smooth_valid (smooth_valid),
      .smooth_pos   (smooth_pos)
   );

   always #2 clk = ~clk; // 4 ns period

   always @(posedge clk) cycle <= cycle + 1;

   ////////////////////
   // reference
   ////////////////////
   function automatic point_t ref_point(input sample_t s);
      int     p15;
      int     p45;
      int     p75;
      int     xi;
      int     yi;
      point_t p;
      p15 = (int'(s.r) * int'(SIN15_Q8)) / 256; // operands positive so this is floor
      p45 = (int'(s.r) * int'(SIN45_Q8)) / 256;
      p75 = (int'(s.r) * int'(SIN75_Q8)) / 256;
      case (s.theta) // x is the cosine side, negative past 90 degrees
         THETA_15:  xi = p75;
         THETA_45:  xi = p45;
         THETA_75:  xi = p15;
         THETA_105: xi = -p15;
         THETA_135: xi = -p45;
         default:   xi = -p75; // 165 and unlisted codes
      endcase
      case (s.theta) // y never goes negative
         THETA_45, THETA_135: yi = p45;
         THETA_75, THETA_105: yi = p75;
         default:             yi = p15;
      endcase
      p.x = xi[8:0];
      p.y = yi[8:0];
      return p;
   endfunction

   // floor of the mean even for odd negative sums
   function automatic logic signed [8:0] floor_mean(input logic signed [8:0] a,
                                                    input logic signed [8:0] b);
      int s;
      s = int'(a) + int'(b);
      if (s < 0 && (s % 2) != 0) s = s / 2 - 1;
      else s = s / 2;
      return s[8:0];
   endfunction

   function automatic logic [7:0] rand_byte();
      int v;
      v = $random(seed);
      return v[7:0];
   endfunction

   ////////////////////
   // compare
   ////////////////////
   function automatic string fix_text(input fix_t f);
      return $sformatf("found=%0b r=%0d theta=%0d x=%0d y=%0d",
                       f.found, f.r, f.theta, f.pos.x, f.pos.y);
   endfunction

   task automatic check_fix(input string name, input fix_t exp, input fix_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL t=%0t %s expected %s, actual %s", $time, name,
                  fix_text(exp), fix_text(act));
      end
   endtask

   task automatic check_point(input string name, input point_t exp, input point_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL t=%0t %s expected x=%0d y=%0d, actual x=%0d y=%0d",
                  $time, name, exp.x, exp.y, act.x, act.y);
      end
   endtask

   // outputs settle after posedge so look at them on the falling edge
   always @(negedge clk) begin
      fix_t   exp_f;
      point_t exp_p;
      if (arst_n) begin
         if (fix_valid) begin
            if (fix_exp_q.size() == 0) begin
               errors++;
               $display("error at %0t: fix_valid pulsed while no fix was due", $time);
            end else begin
               if (fix_cyc_q[0] != cycle) begin
                  errors++;
                  $display("error at %0t: fix_valid came in cycle %0d but was due in cycle %0d",
                           $time, cycle, fix_cyc_q[0]);
               end
               exp_f = fix_exp_q.pop_front();
               void'(fix_cyc_q.pop_front());
               check_fix("fix", exp_f, fix);
            end
         end else if (fix_cyc_q.size() > 0 && cycle > fix_cyc_q[0]) begin
            errors++; // pulse never came
            $display("error at %0t: fix_valid pulse due in cycle %0d is missing",
                     $time, fix_cyc_q[0]);
            void'(fix_exp_q.pop_front());
            void'(fix_cyc_q.pop_front());
         end

         if (smooth_valid) begin
            if (pt_exp_q.size() == 0) begin
               errors++;
               $display("error at %0t: smooth_valid pulsed while no position was due", $time);
            end else begin
               if (pt_cyc_q[0] != cycle) begin
                  errors++;
                  $display("error at %0t: smooth_valid came in cycle %0d but was due in cycle %0d",
                           $time, cycle, pt_cyc_q[0]);
               end
               exp_p = pt_exp_q.pop_front();
               void'(pt_cyc_q.pop_front());
               check_point("smooth_pos", exp_p, smooth_pos);
            end
         end else if (pt_cyc_q.size() > 0 && cycle > pt_cyc_q[0]) begin
            errors++;
            $display("error at %0t: smooth_valid pulse due in cycle %0d is missing",
                     $time, pt_cyc_q[0]);
            void'(pt_exp_q.pop_front());
            void'(pt_cyc_q.pop_front());
         end
      end
   end

   ////////////////////
   // stimulus
   ////////////////////
   // drive one sample and run the tracker and smoother rules on it
   task automatic send_sample(input sample_t s);
      point_t p;
      @(posedge clk);
      #1;
      sample_valid = 1'b1;
      sample       = s;
      p = ref_point(s);
      if (s.r != 8'd0 && (!best.found || s.r < best.r)) begin // ties keep the earlier one
         best.found = 1'b1;
         best.r     = s.r;
         best.theta = s.theta;
         best.pos   = p;
      end
      if (s.theta == THETA_LAST) begin
         fix_exp_q.push_back(best);
         fix_cyc_q.push_back(cycle + 1);
         if (best.found) begin
            if (!ref_primed) ref_smooth = best.pos;
            else begin
               ref_smooth.x = floor_mean(ref_smooth.x, best.pos.x);
               ref_smooth.y = floor_mean(ref_smooth.y, best.pos.y);
            end
            ref_primed = 1'b1;
            pt_exp_q.push_back(ref_smooth);
            pt_cyc_q.push_back(cycle + 2);
         end
         best = '0;
      end
   endtask

   task automatic send_sweep();
      sample_t s;
      for (int i = 0; i < 6; i++) begin
         s.theta = theta_codes[i];
         s.r     = sweep_r[i];
         send_sample(s);
      end
   endtask

   task automatic release_bus();
      @(posedge clk);
      #1;
      sample_valid = 1'b0;
      sample       = '0;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      arst_n       = 1'b0;
      sample_valid = 1'b0;
      sample       = '0;
      best         = '0; // model restarts with the DUT
      ref_primed   = 1'b0;
      ref_smooth   = '0;
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = errors;
      test_chk0 = checks;
   endtask

   // let every due pulse arrive and then report the test
   task automatic end_test();
      int n;
      release_bus();
      n = 0;
      while ((fix_cyc_q.size() != 0 || pt_cyc_q.size() != 0) && n < 50) begin
         @(posedge clk);
         n++;
      end
      if (fix_cyc_q.size() != 0 || pt_cyc_q.size() != 0) begin
         errors++;
         $display("timeout: %0d fix and %0d smooth pulses never arrived",
                  fix_cyc_q.size(), pt_cyc_q.size());
         fix_exp_q.delete();
         fix_cyc_q.delete();
         pt_exp_q.delete();
         pt_cyc_q.delete();
      end
      repeat (2) @(posedge clk);
      tests++;
      $display("test %s done: %0d checks, %0d errors", test_name,
               checks - test_chk0, errors - test_err0);
   endtask

   initial begin
      logic [7:0] v;
      theta_codes = '{THETA_15, THETA_45, THETA_75, THETA_105, THETA_135, THETA_165};
      arst_n       = 1'b0;
      sample_valid = 1'b0;
      sample       = '0;
      best         = '0;
      ref_primed   = 1'b0;
      ref_smooth   = '0;
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;

      // one echo per sweep walked across all bearings
      begin_test("conversion");
      for (int k = 0; k < 3; k++) begin
         for (int b = 0; b < 6; b++) begin
            for (int i = 0; i < 6; i++) sweep_r[i] = 8'd0;
            v = rand_byte();
            if (v == 8'd0) v = 8'd128;
            sweep_r[b] = (k == 0) ? 8'd255 : (k == 1) ? 8'd1 : v;
            send_sweep();
         end
      end
      end_test();

      // narrow range band so ties show up often
      begin_test("nearest");
      for (int k = 0; k < 20; k++) begin
         for (int i = 0; i < 6; i++) begin
            v = rand_byte();
            sweep_r[i] = (v[1:0] == 2'd0) ? 8'd0 : 8'd40 + {5'd0, v[4:2]};
         end
         send_sweep();
      end
      end_test();

      begin_test("empty sweep");
      for (int i = 0; i < 6; i++) sweep_r[i] = 8'd0;
      send_sweep(); // fix with found clear and no smooth pulse
      end_test();

      // sweeps with no idle cycle in between
      begin_test("back to back");
      for (int k = 0; k < 8; k++) begin
         for (int i = 0; i < 6; i++) sweep_r[i] = rand_byte();
         if (k == 3) for (int i = 0; i < 6; i++) sweep_r[i] = 8'd0;
         send_sweep();
      end
      end_test();

      begin_test("smoothing");
      apply_reset(); // first fix must pass straight through
      for (int k = 0; k < 12; k++) begin
         for (int i = 0; i < 6; i++) sweep_r[i] = rand_byte();
         send_sweep();
      end
      end_test();

      // close echoes then reset so stale state would win the next search
      begin_test("reset mid sweep");
      sweep_r = '{8'd5, 8'd6, 8'd7, 8'd0, 8'd0, 8'd0};
      for (int i = 0; i < 3; i++) send_sample({theta_codes[i], sweep_r[i]});
      apply_reset();
      sweep_r = '{8'd0, 8'd150, 8'd120, 8'd200, 8'd130, 8'd0};
      send_sweep();
      sweep_r = '{8'd90, 8'd0, 8'd0, 8'd0, 8'd0, 8'd60};
      send_sweep();
      end_test();

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/locator_top.sv
`timescale 1ns/1ps
`default_nettype none

// locator back end, samples in, fix and smoothed position out
module locator_top import locator_pkg::*; (
   input  wire logic    clk,
   input  wire logic    arst_n,
   input  wire logic    sample_valid,
   input  wire sample_t sample,
   output logic         fix_valid,    // 1 cycle after last sample
   output fix_t         fix,
   output logic         smooth_valid, // 2 cycles after last sample
   output point_t       smooth_pos
);

   point_t pos; // combinational position of the incoming sample

   ////////////////////
   // datapath
   ////////////////////
   polar_to_cartesian u_polar_to_cartesian (
      .sample (sample),
      .pos    (pos)
   );

   nearest_target_tracker u_nearest_target_tracker (
      .clk          (clk),
      .arst_n       (arst_n),
      .sample_valid (sample_valid),
      .sample       (sample),
      .pos          (pos),
      .fix_valid    (fix_valid),
      .fix          (fix)
   );

   // fed straight from the tracker registers
   fix_smoother u_fix_smoother (
      .clk          (clk),
      .arst_n       (arst_n),
      .fix_valid    (fix_valid),
      .fix          (fix),
      .smooth_valid (smooth_valid),
      .smooth_pos   (smooth_pos)
   );

endmodule

`default_nettype wire

// File: logic/fix_smoother.sv
`timescale 1ns/1ps
`default_nettype none

// running two-point average of found fixes
module fix_smoother import locator_pkg::*; (
   input  wire logic clk,
   input  wire logic arst_n,
   input  wire logic fix_valid,
   input  wire fix_t fix,
   output logic      smooth_valid,
   output point_t    smooth_pos
);

   logic              primed; // a found fix has been seen since reset
   logic signed [9:0] sum_x;  // one guard bit, no overflow
   logic signed [9:0] sum_y;
   logic signed [9:0] half_x;
   logic signed [9:0] half_y;
   point_t            avg;

   ////////////////////
   // average
   ////////////////////
   always_comb begin
      sum_x  = {smooth_pos.x[8], smooth_pos.x} + {fix.pos.x[8], fix.pos.x}; // sign extend
      sum_y  = {smooth_pos.y[8], smooth_pos.y} + {fix.pos.y[8], fix.pos.y};
      half_x = sum_x >>> 1; // floor, rounds toward minus infinity
      half_y = sum_y >>> 1;
      avg.x  = half_x[8:0]; // always back in 9 bit range
      avg.y  = half_y[8:0];
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         primed       <= 1'b0;
         smooth_valid <= 1'b0;
         smooth_pos   <= '0;
      end else begin
         smooth_valid <= 1'b0;

         // empty sweeps are dropped here
         if (fix_valid && fix.found) begin
            smooth_valid <= 1'b1;
            primed       <= 1'b1;
            if (!primed) begin
               smooth_pos <= fix.pos; // first fix seeds the filter
            end else begin
               smooth_pos <= avg;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/nearest_target_tracker.sv
`timescale 1ns/1ps
`default_nettype none

// closest echo per sweep, published when the 165 sample arrives
module nearest_target_tracker import locator_pkg::*; (
   input  wire logic    clk,
   input  wire logic    arst_n,
   input  wire logic    sample_valid, // one cycle strobe
   input  wire sample_t sample,
   input  wire point_t  pos,          // cartesian form of sample, same cycle
   output logic         fix_valid,
   output fix_t         fix
);

   fix_t cand_q; // best so far in this sweep, all zero while empty
   fix_t cand_d; // candidate once the current sample is folded in
   logic closer; // current sample beats the held one
   logic is_last;

   ////////////////////
   // search
   ////////////////////
   always_comb begin
      // zero range is no echo, ties keep the older sample
      closer  = (sample.r != 8'd0) && (!cand_q.found || (sample.r < cand_q.r));
      is_last = (sample.theta == THETA_LAST);

      cand_d = cand_q;
      if (closer) begin
         cand_d.found = 1'b1;
         cand_d.r     = sample.r;
         cand_d.theta = sample.theta;
         cand_d.pos   = pos;
      end
   end

   ////////////////////
   // state
   ////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cand_q    <= '0;
         fix_valid <= 1'b0;
         fix       <= '0;
      end else begin
         fix_valid <= 1'b0; // pulse only

         if (sample_valid) begin
            if (is_last) begin
               // last bearing counts toward its own sweep
               fix_valid <= 1'b1;
               fix       <= cand_d; // empty sweep leaves this all zero
               cand_q    <= '0;     // next sweep starts clean
            end else begin
               cand_q <= cand_d;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/polar_to_cartesian.sv
`timescale 1ns/1ps
`default_nettype none

// bearing + range in, signed x/y out, no clock
module polar_to_cartesian import locator_pkg::*; (
   input  wire sample_t sample,
   output point_t       pos
);

   logic [7:0] rsin_15; // r * sin 15
   logic [7:0] rsin_45; // r * sin 45
   logic [7:0] rsin_75; // r * sin 75

   // magnitudes, shared by all six bearings
   calc_rsin u_calc_rsin (
      .r       (sample.r),
      .rsin_15 (rsin_15),
      .rsin_45 (rsin_45),
      .rsin_75 (rsin_75)
   );

   ////////////////////
   // quadrant select
   ////////////////////
   // cos of the bearing is sin of its complement, so x swaps 15 and 75
   // past 90 degrees x flips sign, y stays positive
   always_comb begin
      case (sample.theta)
         THETA_15: begin
            pos.x = {1'b0, rsin_75};
            pos.y = {1'b0, rsin_15};
         end
         THETA_45: begin
            pos.x = {1'b0, rsin_45};
            pos.y = {1'b0, rsin_45};
         end
         THETA_75: begin
            pos.x = {1'b0, rsin_15};
            pos.y = {1'b0, rsin_75};
         end
         THETA_105: begin // mirror of 75
            pos.x = -{1'b0, rsin_15}; // true negate, not a sign bit
            pos.y = {1'b0, rsin_75};
         end
         THETA_135: begin // mirror of 45
            pos.x = -{1'b0, rsin_45};
            pos.y = {1'b0, rsin_45};
         end
         default: begin // 165 and any stray code
            pos.x = -{1'b0, rsin_75};
            pos.y = {1'b0, rsin_15};
         end
      endcase
   end

endmodule

`default_nettype wire

// File: logic/calc_rsin.sv
`timescale 1ns/1ps
`default_nettype none

// r * sin(theta) for the three magnitudes the six bearings need
module calc_rsin import locator_pkg::*; (
   input  wire logic [7:0] r,
   output logic      [7:0] rsin_15,
   output logic      [7:0] rsin_45,
   output logic      [7:0] rsin_75
);

   ////////////////////
   // q8 product
   ////////////////////
   // constant is fixed per call so synthesis keeps only the set-bit adders
   function automatic logic [7:0] rsin_q8(input logic [7:0] r_in, input logic [7:0] k);
      logic [15:0] acc;
      acc = '0;
      for (int i = 0; i < 8; i++) begin
         if (k[i]) begin
            acc = acc + ({8'd0, r_in} << i); // one partial product per set bit
         end
      end
      return acc[15:8]; // drop the q8 fraction, floor
   endfunction

   // 66  = 64 + 2           -> two terms
   // 181 = 128 + 32 + 16 + 4 + 1
   // 247 = everything but bit 3
   // max product 255 * 247 still fits 16 bits
   always_comb begin
      rsin_15 = rsin_q8(r, SIN15_Q8);
      rsin_45 = rsin_q8(r, SIN45_Q8);
      rsin_75 = rsin_q8(r, SIN75_Q8);
   end

endmodule

`default_nettype wire

// File: logic/locator_pkg.sv
`default_nettype none

package locator_pkg;

   ////////////////////
   // bearing codes
   ////////////////////
   // theta counts in 15 degree steps, only odd multiples are used
   localparam logic [3:0] THETA_15  = 4'd1;
   localparam logic [3:0] THETA_45  = 4'd3;
   localparam logic [3:0] THETA_75  = 4'd5;
   localparam logic [3:0] THETA_105 = 4'd7;
   localparam logic [3:0] THETA_135 = 4'd9;
   localparam logic [3:0] THETA_165 = 4'd11;
   localparam logic [3:0] THETA_LAST = THETA_165; // bearing that closes a sweep

   ////////////////////
   // sine constants
   ////////////////////
   // q8 fixed point, sin * 256 rounded
   localparam logic [7:0] SIN15_Q8 = 8'd66;  // 0.2588
   localparam logic [7:0] SIN45_Q8 = 8'd181; // 0.7071
   localparam logic [7:0] SIN75_Q8 = 8'd247; // 0.9659

   ////////////////////
   // shared words
   ////////////////////
   // one range sample from the transducer, theta in the upper nibble
   typedef struct packed {
      logic [3:0] theta; // bearing code
      logic [7:0] r;     // range, zero when nothing came back
   } sample_t;

   // cartesian position, both axes two's complement
   typedef struct packed {
      logic signed [8:0] x;
      logic signed [8:0] y;
   } point_t;

   // nearest echo of one sweep
   typedef struct packed {
      logic       found; // sweep had at least one echo
      logic [7:0] r;
      logic [3:0] theta;
      point_t     pos;
   } fix_t;

endpackage

`default_nettype wire
